/* Makefile */
# Verilator build and run of the preprocessing testbench

TOOL     ?= verilator
FLAGS    ?= --binary --assert -j 0
TOP      ?= preprocessing_tb
FILELIST ?= preprocessing_top.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || echo "Some tests failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@echo "simulation finished without failure"

clean:
	rm -rf $(BUILD) $(LOG)

/* preprocessing_top.f */
rtl/prep_pkg.sv
rtl/filter_ctrl_if.sv
rtl/stream_ctrl.sv
rtl/gauss_row_filter.sv
rtl/box_row_filter.sv
rtl/rho_combiner.sv
rtl/preprocessing_top.sv
verification/preprocessing_tb.sv

/* rtl/box_row_filter.sv */
// Three tap box filter along the row for one channel.
// Takes the Gaussian result on box_shift and registers the plain sum
// on box_load. No divide by 3, the stage has gain 3.

`timescale 1ns/100ps
`default_nettype none

module box_row_filter (
    input  wire logic             clk_i,

    filter_ctrl_if.dp             ctrl_if,

    input  wire prep_pkg::pixel_t gauss_i,
    output prep_pkg::box_t        box_o
);

    import prep_pkg::*;

    pixel_t win_q [BOX_TAPS];
    box_t   sum_w;

    always_ff @(posedge clk_i) begin
        if (ctrl_if.box_shift) begin
            win_q[0] <= gauss_i;
            for (int i = 1; i < BOX_TAPS; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    always_comb begin
        sum_w = '0;
        for (int i = 0; i < BOX_TAPS; i++) begin
            sum_w = sum_w + box_t'(win_q[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_if.box_load) begin
            box_o <= sum_w;
        end
    end

endmodule

`default_nettype wire

/* rtl/filter_ctrl_if.sv */
// Stage enables from the stream controller to the filter datapath.
// The controller drives through ctrl, each datapath stage listens through dp.

`timescale 1ns/100ps
`default_nettype none

interface filter_ctrl_if;

    logic gauss_shift;
    logic gauss_load;
    logic box_shift;
    logic box_load;
    logic comb_load;

    modport ctrl (
        output gauss_shift,
        output gauss_load,
        output box_shift,
        output box_load,
        output comb_load
    );

    modport dp (
        input gauss_shift,
        input gauss_load,
        input box_shift,
        input box_load,
        input comb_load
    );

endinterface

`default_nettype wire

/* rtl/gauss_row_filter.sv */
// Five tap binomial row filter for one pixel channel.
// The window shifts on gauss_shift; the weighted sum divided by 16 is
// registered on gauss_load, one cycle after the sample arrives.

`timescale 1ns/100ps
`default_nettype none

module gauss_row_filter (
    input  wire logic             clk_i,

    filter_ctrl_if.dp             ctrl_if,

    input  wire prep_pkg::pixel_t pix_i,
    output prep_pkg::pixel_t      gauss_o
);

    import prep_pkg::*;

    pixel_t     win_q [GAUSS_TAPS];
    gauss_acc_t acc_w;

    //////////////////////////////////////////////////
    // row window, newest sample at index 0
    always_ff @(posedge clk_i) begin
        if (ctrl_if.gauss_shift) begin
            win_q[0] <= pix_i;
            for (int i = 1; i < GAUSS_TAPS; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    // fold the symmetric taps before weighting
    always_comb begin
        acc_w = GAUSS_W0 * (gauss_acc_t'(win_q[0]) + gauss_acc_t'(win_q[4]))
              + GAUSS_W1 * (gauss_acc_t'(win_q[1]) + gauss_acc_t'(win_q[3]))
              + GAUSS_W2 * gauss_acc_t'(win_q[2]);
    end

    // weights sum to 16, result fits a pixel
    always_ff @(posedge clk_i) begin
        if (ctrl_if.gauss_load) begin
            gauss_o <= pixel_t'(acc_w >> GAUSS_SHIFT);
        end
    end

endmodule

`default_nettype wire

/* rtl/prep_pkg.sv */
// Shared widths, kernel weights and data types for the row preprocessing core.
// Modules import this package inside their body. Port lists use scoped names.

`default_nettype none

package prep_pkg;

    //////////////////////////////////////////////////
    // widths
    localparam int PIX_W   = 8;
    localparam int COORD_W = 16;

    //////////////////////////////////////////////////
    // binomial row kernel 1 4 6 4 1, divided by 16
    localparam int GAUSS_TAPS  = 5;
    localparam int GAUSS_SHIFT = 4;

    // centre weight is GAUSS_W2, kernel is symmetric
    localparam logic [3:0] GAUSS_W0 = 4'd1;
    localparam logic [3:0] GAUSS_W1 = 4'd4;
    localparam logic [3:0] GAUSS_W2 = 4'd6;

    // plain 3-tap sum, gain 3
    localparam int BOX_TAPS = 3;

    //////////////////////////////////////////////////
    // pipeline timing
    localparam int PIPE_DEPTH = 5;
    localparam int OUT_LAG    = 3;

    //////////////////////////////////////////////////
    // types
    typedef logic [PIX_W-1:0] pixel_t;

    // weighted sum before the divide by 16
    typedef logic [PIX_W+GAUSS_SHIFT-1:0] gauss_acc_t;

    // 3 * 255 needs two extra bits
    typedef logic [PIX_W+1:0]        box_t;
    typedef logic [PIX_W+1:0]        ia_t;
    typedef logic signed [PIX_W+1:0] it_t;

    typedef logic [COORD_W-1:0] coord_t;

endpackage

`default_nettype wire

/* rtl/preprocessing_top.sv */
// Top level of the row preprocessing core.
// Two raster pixel streams go through a Gaussian and a box row filter each,
// then are combined into i_a and i_t with the centre pixel coordinate.
// Free-running valid stream, no back-pressure.

`timescale 1ns/100ps
`default_nettype none

module preprocessing_top #(
    parameter int IMAGE_WIDTH = 16
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,

    input  wire prep_pkg::pixel_t rho_plus_i,
    input  wire prep_pkg::pixel_t rho_minus_i,
    input  wire prep_pkg::coord_t col_i,
    input  wire prep_pkg::coord_t row_i,
    input  wire logic             valid_i,

    output prep_pkg::ia_t         i_a_o,
    output prep_pkg::it_t         i_t_o,
    output prep_pkg::coord_t      col_o,
    output prep_pkg::coord_t      row_o,
    output logic                  valid_o
);

    import prep_pkg::*;

    filter_ctrl_if ctrl_if ();

    pixel_t rho_plus_gauss_w;
    pixel_t rho_minus_gauss_w;
    box_t   rho_plus_box_w;
    box_t   rho_minus_box_w;

    //////////////////////////////////////////////////
    // control, valid and coordinates
    stream_ctrl #(
        .IMAGE_WIDTH(IMAGE_WIDTH)
    ) u_stream_ctrl (
        .clk_i  (clk_i),
        .rst_i  (rst_i),

        .valid_i(valid_i),
        .col_i  (col_i),
        .row_i  (row_i),

        .ctrl_if(ctrl_if.ctrl),

        .col_o  (col_o),
        .row_o  (row_o),
        .valid_o(valid_o)
    );

    //////////////////////////////////////////////////
    // rho plus channel
    gauss_row_filter u_rho_plus_gauss (
        .clk_i  (clk_i),
        .ctrl_if(ctrl_if.dp),
        .pix_i  (rho_plus_i),
        .gauss_o(rho_plus_gauss_w)
    );

    box_row_filter u_rho_plus_box (
        .clk_i  (clk_i),
        .ctrl_if(ctrl_if.dp),
        .gauss_i(rho_plus_gauss_w),
        .box_o  (rho_plus_box_w)
    );

    //////////////////////////////////////////////////
    // rho minus channel
    gauss_row_filter u_rho_minus_gauss (
        .clk_i  (clk_i),
        .ctrl_if(ctrl_if.dp),
        .pix_i  (rho_minus_i),
        .gauss_o(rho_minus_gauss_w)
    );

    box_row_filter u_rho_minus_box (
        .clk_i  (clk_i),
        .ctrl_if(ctrl_if.dp),
        .gauss_i(rho_minus_gauss_w),
        .box_o  (rho_minus_box_w)
    );

    //////////////////////////////////////////////////
    // i_a and i_t
    rho_combiner u_rho_combiner (
        .clk_i  (clk_i),
        .ctrl_if(ctrl_if.dp),
        .plus_i (rho_plus_box_w),
        .minus_i(rho_minus_box_w),
        .i_a_o  (i_a_o),
        .i_t_o  (i_t_o)
    );

endmodule

`default_nettype wire

/* rtl/rho_combiner.sv */
// Combines the two smoothed channels into i_a and i_t.
// i_a is the half sum, i_t the half difference plus minus minus,
// both registered on comb_load.

`timescale 1ns/100ps
`default_nettype none

module rho_combiner (
    input  wire logic           clk_i,

    filter_ctrl_if.dp           ctrl_if,

    input  wire prep_pkg::box_t plus_i,
    input  wire prep_pkg::box_t minus_i,

    output prep_pkg::ia_t       i_a_o,
    output prep_pkg::it_t       i_t_o
);

    import prep_pkg::*;

    // one extra bit for carry and sign
    logic [$bits(box_t):0]        sum_w;
    logic signed [$bits(box_t):0] diff_w;
    logic signed [$bits(box_t):0] half_diff_w;

    assign sum_w       = {1'b0, plus_i} + {1'b0, minus_i};
    assign diff_w      = $signed({1'b0, plus_i}) - $signed({1'b0, minus_i});
    // arithmetic shift rounds toward minus infinity
    assign half_diff_w = diff_w >>> 1;

    always_ff @(posedge clk_i) begin
        if (ctrl_if.comb_load) begin
            i_a_o <= ia_t'(sum_w >> 1);
            i_t_o <= it_t'(half_diff_w);
        end
    end

    // box outputs never exceed 3 * 255, so the half difference stays inside it_t
    a_diff_range: assert property (@(posedge clk_i)
        ctrl_if.comb_load |-> diff_w <= BOX_TAPS * ((1 << PIX_W) - 1)
                           && diff_w >= -(BOX_TAPS * ((1 << PIX_W) - 1)));

endmodule

`default_nettype wire

/* rtl/stream_ctrl.sv */
// Stream controller for the row preprocessing pipeline.
// Delays valid, column and row alongside the data, drives the stage enables
// and qualifies the output once both row windows lie inside the row.

`timescale 1ns/100ps
`default_nettype none

module stream_ctrl #(
    parameter int IMAGE_WIDTH = 16
) (
    input  wire logic            clk_i,
    input  wire logic            rst_i,

    input  wire logic            valid_i,
    input  wire prep_pkg::coord_t col_i,
    input  wire prep_pkg::coord_t row_i,

    filter_ctrl_if.ctrl          ctrl_if,

    output prep_pkg::coord_t     col_o,
    output prep_pkg::coord_t     row_o,
    output logic                 valid_o
);

    import prep_pkg::*;

    logic [PIPE_DEPTH-1:0] valid_q;
    logic [PIPE_DEPTH-1:0] full_q;
    coord_t                col_q [PIPE_DEPTH];
    coord_t                row_q [PIPE_DEPTH];
    logic                  full_w;

    // input stream tracking
    coord_t                last_row_q;
    logic                  seen_q;

    // gauss window full at col 4, box over three gauss results at col 6
    assign full_w = col_i >= coord_t'(GAUSS_TAPS + BOX_TAPS - 2);

    //////////////////////////////////////////////////
    // valid pipe, one bit per stage
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[PIPE_DEPTH-2:0], valid_i};
        end
    end

    // coordinates travel next to valid, output centre lags by OUT_LAG
    always_ff @(posedge clk_i) begin
        full_q   <= {full_q[PIPE_DEPTH-2:0], full_w};
        col_q[0] <= col_i - coord_t'(OUT_LAG);
        row_q[0] <= row_i;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            col_q[i] <= col_q[i-1];
            row_q[i] <= row_q[i-1];
        end
    end

    //////////////////////////////////////////////////
    // stage enables
    assign ctrl_if.gauss_shift = valid_i;
    assign ctrl_if.gauss_load  = valid_q[0];
    assign ctrl_if.box_shift   = valid_q[1];
    assign ctrl_if.box_load    = valid_q[2];
    assign ctrl_if.comb_load   = valid_q[3];

    assign valid_o = valid_q[PIPE_DEPTH-1] & full_q[PIPE_DEPTH-1];
    assign col_o   = col_q[PIPE_DEPTH-1];
    assign row_o   = row_q[PIPE_DEPTH-1];

    //////////////////////////////////////////////////
    // input stream checks
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            seen_q <= 1'b0;
        end else if (valid_i) begin
            seen_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            last_row_q <= row_i;
        end
    end

    a_col_in_row: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> col_i < coord_t'(IMAGE_WIDTH));

    // the window logic relies on every row starting at column 0
    a_row_restart: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i && (!seen_q || row_i != last_row_q) |-> col_i == '0);

endmodule

`default_nettype wire

/* verification/preprocessing_tb.sv */
// Self-checking testbench for the row preprocessing core.
// Streams constant and random 16 x 4 images through preprocessing_top and
// compares each output with a reference model of the row filters.

`timescale 1ns/100ps
`default_nettype none

module preprocessing_tb;

    localparam int IMG_W         = 16;
    localparam int IMG_ROWS      = 4;
    localparam int FIRST_C       = 3;
    localparam int LAST_C        = IMG_W - 4;
    localparam int PER_IMG       = IMG_ROWS * (LAST_C - FIRST_C + 1);
    localparam int LATENCY       = 5;
    localparam int DRAIN_TIMEOUT = 400;

    typedef struct packed {
        int ia;
        int it;
        int col;
        int row;
    } expect_t;

    logic              clk_i = 1'b0;
    logic              rst_i;
    logic [7:0]        rho_plus_i;
    logic [7:0]        rho_minus_i;
    logic [15:0]       col_i;
    logic [15:0]       row_i;
    logic              valid_i;
    logic [9:0]        i_a_o;
    logic signed [9:0] i_t_o;
    logic [15:0]       col_o;
    logic [15:0]       row_o;
    logic              valid_o;

    logic [7:0] plus_img  [IMG_ROWS][IMG_W];
    logic [7:0] minus_img [IMG_ROWS][IMG_W];
    int         in_edge   [IMG_ROWS][IMG_W];
    expect_t    exp_q     [$];

    logic [31:0] rng_state    = 32'hf268ee08;
    int          cycle_cnt    = 0;
    int          err_cnt      = 0;
    int          chk_cnt      = 0;
    int          out_cnt      = 0;
    int          neg_cnt      = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          err_base     = 0;
    int          out_base     = 0;
    int          neg_base     = 0;

    preprocessing_top #(
        .IMAGE_WIDTH(IMG_W)
    ) dut0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rho_plus_i (rho_plus_i),
        .rho_minus_i(rho_minus_i),
        .col_i      (col_i),
        .row_i      (row_i),
        .valid_i    (valid_i),
        .i_a_o      (i_a_o),
        .i_t_o      (i_t_o),
        .col_o      (col_o),
        .row_o      (row_o),
        .valid_o    (valid_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////////////////////////
    // random source and reference model
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int pixel_at(input bit minus_sel, input int r, input int x);
        if (minus_sel) begin
            return int'(minus_img[r][x]);
        end
        return int'(plus_img[r][x]);
    endfunction

    // binomial 1 4 6 4 1 over 16 with truncation
    function automatic int gauss_ref(input bit minus_sel, input int r, input int x);
        int acc;
        acc = pixel_at(minus_sel, r, x - 2) + 4 * pixel_at(minus_sel, r, x - 1)
            + 6 * pixel_at(minus_sel, r, x) + 4 * pixel_at(minus_sel, r, x + 1)
            + pixel_at(minus_sel, r, x + 2);
        return acc / 16;
    endfunction

    function automatic expect_t expected_at(input int r, input int c);
        expect_t e;
        int      box_p;
        int      box_m;
        int      diff;
        box_p = 0;
        box_m = 0;
        for (int d = -1; d <= 1; d++) begin
            box_p += gauss_ref(1'b0, r, c + d);
            box_m += gauss_ref(1'b1, r, c + d);
        end
        diff  = box_p - box_m;
        e.ia  = (box_p + box_m) / 2;
        // odd negative differences round down to the floor
        e.it  = (diff >= 0) ? diff / 2 : -((1 - diff) / 2);
        e.col = c;
        e.row = r;
        return e;
    endfunction

    //////////////////////////////////////////////////
    // checks and stimulus
    task automatic check_value(input string what, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic fill_constant(input logic [7:0] v_plus, input logic [7:0] v_minus);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                plus_img[r][c]  = v_plus;
                minus_img[r][c] = v_minus;
            end
        end
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                rnd             = next_rand();
                plus_img[r][c]  = rnd[7:0];
                minus_img[r][c] = rnd[15:8];
            end
        end
    endtask

    task automatic queue_image();
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = FIRST_C; c <= LAST_C; c++) begin
                exp_q.push_back(expected_at(r, c));
            end
        end
    endtask

    // gap_mode 0 back to back, 1 random gaps, 2 seven idle cycles per sample
    task automatic stream_image(input int gap_mode);
        logic [31:0] rnd;
        int          gap;
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                @(posedge clk_i);
                rho_plus_i  <= plus_img[r][c];
                rho_minus_i <= minus_img[r][c];
                col_i       <= 16'(c);
                row_i       <= 16'(r);
                valid_i     <= 1'b1;
                gap = 0;
                if (gap_mode == 1) begin
                    rnd = next_rand();
                    gap = (rnd[1:0] == 2'd0) ? int'(rnd[3:2]) + 1 : 0;
                end else if (gap_mode == 2) begin
                    gap = 7;
                end
                repeat (gap) begin
                    @(posedge clk_i);
                    valid_i <= 1'b0;
                end
            end
        end
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected outputs still missing after %0d cycles",
                     exp_q.size(), waited);
            $display("Some tests failed");
            $finish;
        end else begin
            // idle so that late extra outputs show up
            repeat (8) @(posedge clk_i);
        end
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = err_cnt - err_base;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errs);
        end
        err_base = err_cnt;
        out_base = out_cnt;
        neg_base = neg_cnt;
    endtask

    //////////////////////////////////////////////////
    // output comparison on the falling edge
    always @(negedge clk_i) begin : compare_outputs
        expect_t e;
        if (rst_i) begin
            check_value("valid_o in reset", 32'(valid_o), 0);
        end else begin
            if (valid_i === 1'b1) begin
                in_edge[int'(row_i)][int'(col_i)] = cycle_cnt + 1;
            end
            if (valid_o === 1'b1) begin
                out_cnt++;
                if (i_t_o < 0) begin
                    neg_cnt++;
                end
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("unexpected output at %0d ns for row %0d col %0d",
                             $time, row_o, col_o);
                end else begin
                    e = exp_q.pop_front();
                    check_value("i_a_o", 32'(i_a_o), e.ia);
                    check_value("i_t_o", 32'(i_t_o), e.it);
                    check_value("col_o", 32'(col_o), e.col);
                    check_value("row_o", 32'(row_o), e.row);
                    check_value("cycles from input to output",
                                cycle_cnt + 1 - in_edge[e.row][e.col + 3], LATENCY);
                end
            end else if (valid_o !== 1'b0) begin
                err_cnt++;
                $display("valid_o is unknown at %0d ns", $time);
            end
        end
    end

    initial begin : main_sequence
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        rho_plus_i  = '0;
        rho_minus_i = '0;
        col_i       = '0;
        row_i       = '0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        repeat (6) begin
            @(negedge clk_i);
            check_value("valid_o after reset", 32'(valid_o), 0);
        end
        end_test(1, "valid_o low in and after reset");

        fill_constant(8'd255, 8'd255);
        queue_image();
        stream_image(0);
        wait_drain();
        fill_constant(8'd37, 8'd37);
        queue_image();
        stream_image(0);
        wait_drain();
        check_value("outputs in test 2", out_cnt - out_base, 2 * PER_IMG);
        end_test(2, "constant image");

        fill_random();
        queue_image();
        stream_image(0);
        wait_drain();
        check_value("outputs in test 3", out_cnt - out_base, PER_IMG);
        if (neg_cnt == neg_base) begin
            err_cnt++;
            $display("no negative i_t_o was seen with random images");
        end
        end_test(3, "random image back to back");

        // same image again with holes in valid_i
        queue_image();
        stream_image(1);
        wait_drain();
        check_value("outputs in test 4", out_cnt - out_base, PER_IMG);
        end_test(4, "random gaps in valid_i");

        queue_image();
        stream_image(2);
        wait_drain();
        check_value("outputs in test 5", out_cnt - out_base, PER_IMG);
        end_test(5, "isolated samples and latency");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
